// File: flist.f
arch_pkg.sv
rob_pkg.sv
rob_ptrs.sv
rob_entries.sv
commit_ctrl.sv
reorder_buffer.sv
tb_clock_gen.sv
reorder_buffer_tb.sv

// File: Bender.yml
package:
  name: reorder_buffer

sources:
  - arch_pkg.sv
  - rob_pkg.sv
  - rob_ptrs.sv
  - rob_entries.sv
  - commit_ctrl.sv
  - reorder_buffer.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - reorder_buffer_tb.sv

// File: reorder_buffer_tb.sv
/* reorder buffer testbench */

`timescale 1ns/1ps

module reorder_buffer_tb;

	localparam int ROB_SIZE   = rob_pkg::ROB_DEPTH;
	localparam int IDX_W      = $clog2(ROB_SIZE);
	localparam int N_DISPATCH = 200;                  // planned dispatches
	localparam int MAX_CYCLES = 4 * N_DISPATCH + 100;

	logic clock, rst_n;
	logic inst1_load, inst1_is_branch, inst1_is_halt, inst1_is_illegal;
	logic inst2_load, inst2_is_branch, inst2_is_halt, inst2_is_illegal;
	arch_pkg::addr_t inst1_pc, inst2_pc, cdb1_value, cdb2_value;
	arch_pkg::addr_t commit1_pc, commit2_pc, redirect_pc;
	arch_pkg::arn_t  inst1_arn_dest, inst2_arn_dest, commit1_arn_dest, commit2_arn_dest;
	arch_pkg::prn_t  inst1_prn_dest, inst2_prn_dest, commit1_prn_dest, commit2_prn_dest;
	logic cdb1_valid, cdb1_mispredict, cdb2_valid, cdb2_mispredict;
	logic [IDX_W-1:0] cdb1_rob_idx, cdb2_rob_idx, inst1_rob_idx, inst2_rob_idx;
	logic rob_full, commit1_valid, commit2_valid, commit1_wr_en, commit2_wr_en, redirect_valid;
	logic [3:0] completed_insts;
	arch_pkg::error_code_e error_status;

	// reference model per buffer entry plus program order
	int                    order[$];                  // entry numbers oldest first
	arch_pkg::addr_t       m_pc [ROB_SIZE], m_tgt [ROB_SIZE];
	arch_pkg::arn_t        m_arn [ROB_SIZE];
	arch_pkg::prn_t        m_prn [ROB_SIZE];
	logic                  m_br [ROB_SIZE], m_halt [ROB_SIZE], m_ill [ROB_SIZE];
	logic                  m_exe [ROB_SIZE], m_mis [ROB_SIZE];
	rob_pkg::rob_state_e   m_state;
	arch_pkg::error_code_e m_err, e_code;            // latched code and code raised this cycle
	arch_pkg::addr_t       e_redirect_pc;
	logic                  full_now, c1, c2, e_redirect, halt_sent;
	logic [31:0]           rng_state;
	int m_tail, n_disp, n_commit, error_count, cycle_count, halted_cycles;

	tb_clock_gen clock_gen_i (.clock(clock), .rst_n(rst_n));

	reorder_buffer #(.ROB_SIZE(ROB_SIZE)) reorder_buffer_i (.*);

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic arch_pkg::arn_t random_arn();
		logic [31:0] r;
		r = next_random();
		if (r[1:0] == 2'd0)
			return 5'd31;                               // zero reg often enough to matter
		return r[8:4];
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("mismatch at %0t: %s = %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic push_entry(input arch_pkg::addr_t pc, input arch_pkg::arn_t arn,
		input arch_pkg::prn_t prn, input logic br, input logic halt, input logic ill);
		m_pc[m_tail]   = pc;
		m_arn[m_tail]  = arn;
		m_prn[m_tail]  = prn;
		m_br[m_tail]   = br;
		m_halt[m_tail] = halt;
		m_ill[m_tail]  = ill;
		m_exe[m_tail]  = 1'b0;
		m_mis[m_tail]  = 1'b0;
		order.push_back(m_tail);
		m_tail = (m_tail + 1) % ROB_SIZE;
		n_disp++;
		if (halt || ill)
			halt_sent = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// stimulus 2 ns after the rising edge
	//////////////////////////////////////////////////
	task automatic drive_inputs();
		logic [31:0] r;
		int cand[$];
		int pick;
		r = next_random();
		full_now = (order.size() > ROB_SIZE - 2) || (m_state != rob_pkg::RUN);
		inst1_load = 1'b0;
		inst2_load = 1'b0;
		if ((n_disp < N_DISPATCH) || !halt_sent) begin  // loads while full get dropped
			inst1_load = (r[1:0] != 2'd2);
			inst2_load = r[2] || (r[1:0] == 2'd2);      // slot 2 alone now and then
		end
		inst1_pc         = {next_random(), next_random()};
		inst1_arn_dest   = random_arn();
		inst1_prn_dest   = 6'(next_random());
		inst1_is_branch  = (next_random() % 4) == 0;
		inst1_is_halt    = 1'b0;
		inst1_is_illegal = 1'b0;
		inst2_pc         = {next_random(), next_random()};
		inst2_arn_dest   = random_arn();
		inst2_prn_dest   = 6'(next_random());
		inst2_is_branch  = (next_random() % 4) == 0;
		// a single halt or illegal inst near the end when it will be taken
		if (!full_now && !halt_sent && (n_disp >= N_DISPATCH - 8)) begin
			inst1_load       = 1'b1;
			inst1_is_branch  = 1'b0;
			inst1_is_halt    = r[6];
			inst1_is_illegal = !r[6];
		end
		// complete outstanding entries in random order
		cdb1_valid = 1'b0;
		cdb2_valid = 1'b0;
		foreach (order[i])
			if (!m_exe[order[i]]) cand.push_back(order[i]);
		if ((cand.size() > 0) && (r[4:3] != 2'd0)) begin
			pick            = next_random() % cand.size();
			cdb1_valid      = 1'b1;
			cdb1_rob_idx    = IDX_W'(cand[pick]);
			cdb1_value      = {next_random(), next_random()};
			cdb1_mispredict = m_br[cand[pick]] && !halt_sent && ((next_random() % 8) == 0);
			cand.delete(pick);
		end
		if ((cand.size() > 0) && r[5]) begin
			pick            = next_random() % cand.size();
			cdb2_valid      = 1'b1;
			cdb2_rob_idx    = IDX_W'(cand[pick]);
			cdb2_value      = {next_random(), next_random()};
			cdb2_mispredict = m_br[cand[pick]] && !halt_sent && ((next_random() % 8) == 0);
		end
	endtask

	//////////////////////////////////////////////////
	// expected outputs at the falling edge
	//////////////////////////////////////////////////
	task automatic check_outputs();
		int h0;
		int h1;
		logic stop0;
		c1 = 1'b0;
		c2 = 1'b0;
		e_redirect    = 1'b0;
		e_redirect_pc = '0;
		e_code        = arch_pkg::NO_ERROR;
		if ((m_state == rob_pkg::RUN) && (order.size() >= 1)) begin
			h0    = order[0];
			c1    = m_exe[h0];
			stop0 = (m_br[h0] && m_mis[h0]) || m_halt[h0] || m_ill[h0];   // ends the pair
			if (order.size() >= 2) begin
				h1 = order[1];
				c2 = c1 && m_exe[h1] && !stop0;
			end
		end
		if (c1 && m_br[h0] && m_mis[h0]) begin
			e_redirect    = 1'b1;
			e_redirect_pc = m_tgt[h0];
		end else if (c2 && m_br[h1] && m_mis[h1]) begin
			e_redirect    = 1'b1;
			e_redirect_pc = m_tgt[h1];
		end
		if (c1 && (m_halt[h0] || m_ill[h0]))
			e_code = m_ill[h0] ? arch_pkg::HALTED_ON_ILLEGAL_I1 : arch_pkg::HALTED_ON_HALT_I1;
		else if (c2 && (m_halt[h1] || m_ill[h1]))
			e_code = m_ill[h1] ? arch_pkg::HALTED_ON_ILLEGAL_I2 : arch_pkg::HALTED_ON_HALT_I2;
		check_value("rob_full", rob_full, full_now);
		check_value("commit1_valid", commit1_valid, c1);
		check_value("commit2_valid", commit2_valid, c2);
		check_value("completed_insts", completed_insts, int'(c1) + int'(c2));
		check_value("commit1_wr_en", commit1_wr_en, c1 && (m_arn[h0] != 5'd31));
		check_value("commit2_wr_en", commit2_wr_en, c2 && (m_arn[h1] != 5'd31));
		check_value("redirect_valid", redirect_valid, e_redirect);
		check_value("error_status", error_status, m_err);
		if (c1) begin
			check_value("commit1_pc", commit1_pc, m_pc[h0]);
			check_value("commit1_arn_dest", commit1_arn_dest, m_arn[h0]);
			check_value("commit1_prn_dest", commit1_prn_dest, m_prn[h0]);
		end
		if (c2) begin
			check_value("commit2_pc", commit2_pc, m_pc[h1]);
			check_value("commit2_arn_dest", commit2_arn_dest, m_arn[h1]);
			check_value("commit2_prn_dest", commit2_prn_dest, m_prn[h1]);
		end
		if (e_redirect)
			check_value("redirect_pc", redirect_pc, e_redirect_pc);
		if (!full_now && inst1_load)
			check_value("inst1_rob_idx", inst1_rob_idx, m_tail);
		if (!full_now && inst2_load)
			check_value("inst2_rob_idx", inst2_rob_idx, (m_tail + int'(inst1_load)) % ROB_SIZE);
	endtask

	// what the coming edge does to the model
	task automatic update_model();
		if (c1) void'(order.pop_front());
		if (c2) void'(order.pop_front());
		n_commit += int'(c1) + int'(c2);
		if (cdb1_valid) begin
			m_exe[cdb1_rob_idx] = 1'b1;
			m_mis[cdb1_rob_idx] = cdb1_mispredict;
			m_tgt[cdb1_rob_idx] = cdb1_value;
		end
		if (cdb2_valid) begin
			m_exe[cdb2_rob_idx] = 1'b1;
			m_mis[cdb2_rob_idx] = cdb2_mispredict;
			m_tgt[cdb2_rob_idx] = cdb2_value;
		end
		if (!full_now && inst1_load)
			push_entry(inst1_pc, inst1_arn_dest, inst1_prn_dest, inst1_is_branch,
				inst1_is_halt, inst1_is_illegal);
		if (!full_now && inst2_load)
			push_entry(inst2_pc, inst2_arn_dest, inst2_prn_dest, inst2_is_branch,
				inst2_is_halt, inst2_is_illegal);
		if (m_state == rob_pkg::RUN) begin
			if (e_code != arch_pkg::NO_ERROR) begin
				m_state = rob_pkg::HALTED;
				m_err   = e_code;
			end else if (e_redirect) begin
				m_state   = rob_pkg::FLUSH;               // wrong path incl. this cycle's loads
				order.delete();
				m_tail    = 0;
				halt_sent = 1'b0;                         // a pending halt went with it
			end
		end else if (m_state == rob_pkg::FLUSH) begin
			m_state = rob_pkg::RUN;
		end
		if (m_state == rob_pkg::HALTED)
			halted_cycles++;
	endtask

	initial begin
		rng_state = 32'd83;
		{inst1_load, inst1_is_branch, inst1_is_halt, inst1_is_illegal} = '0;
		{inst2_load, inst2_is_branch, inst2_is_halt, inst2_is_illegal} = '0;
		{inst1_pc, inst1_arn_dest, inst1_prn_dest} = '0;
		{inst2_pc, inst2_arn_dest, inst2_prn_dest} = '0;
		{cdb1_valid, cdb1_rob_idx, cdb1_mispredict, cdb1_value} = '0;
		{cdb2_valid, cdb2_rob_idx, cdb2_mispredict, cdb2_value} = '0;
		m_state = rob_pkg::RUN;
		m_err   = arch_pkg::NO_ERROR;
		{m_tail, n_disp, n_commit, error_count, halted_cycles} = '0;
		halt_sent = 1'b0;
		wait (rst_n === 1'b1);
		while (halted_cycles < 4) begin                 // a few halted cycles with no commits
			@(posedge clock);
			#2;
			drive_inputs();
			@(negedge clock);
			check_outputs();
			update_model();
		end
		if (n_commit < N_DISPATCH / 2) begin
			error_count++;
			$display("only %0d instructions committed before the halt", n_commit);
		end
		$display("errors: %0d, cycles: %0d, dispatched: %0d, committed: %0d",
			error_count, cycle_count, n_disp, n_commit);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: machine not halted after %0d cycles, errors: %0d",
			cycle_count, error_count);
		$display("tests failed");
		$finish;
	end

endmodule

// File: tb_clock_gen.sv
/* testbench clock and reset */

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10,  // ns, 20 ns clock
	parameter int RESET_CYCLES = 5
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#2 rst_n = 1'b1;                  // released off the edge like the other inputs
	end

endmodule

// File: reorder_buffer.sv
/* two wide reorder buffer */

`timescale 1ns/1ps

module reorder_buffer #(
	parameter int ROB_SIZE = rob_pkg::ROB_DEPTH,
	localparam int IDX_W = $clog2(ROB_SIZE)
) (
	input  logic                  clock,
	input  logic                  rst_n,
	// dispatch, program order
	input  logic                  inst1_load,
	input  arch_pkg::addr_t       inst1_pc,
	input  arch_pkg::arn_t        inst1_arn_dest,
	input  arch_pkg::prn_t        inst1_prn_dest,
	input  logic                  inst1_is_branch,
	input  logic                  inst1_is_halt,
	input  logic                  inst1_is_illegal,
	input  logic                  inst2_load,
	input  arch_pkg::addr_t       inst2_pc,
	input  arch_pkg::arn_t        inst2_arn_dest,
	input  arch_pkg::prn_t        inst2_prn_dest,
	input  logic                  inst2_is_branch,
	input  logic                  inst2_is_halt,
	input  logic                  inst2_is_illegal,
	// result bus
	input  logic                  cdb1_valid,
	input  logic [IDX_W-1:0]      cdb1_rob_idx,
	input  logic                  cdb1_mispredict,
	input  arch_pkg::addr_t       cdb1_value,
	input  logic                  cdb2_valid,
	input  logic [IDX_W-1:0]      cdb2_rob_idx,
	input  logic                  cdb2_mispredict,
	input  arch_pkg::addr_t       cdb2_value,
	output logic [IDX_W-1:0]      inst1_rob_idx,   // same cycle as the load
	output logic [IDX_W-1:0]      inst2_rob_idx,
	output logic                  rob_full,        // stall dispatch
	// commit
	output logic                  commit1_valid,
	output arch_pkg::addr_t       commit1_pc,
	output arch_pkg::arn_t        commit1_arn_dest,
	output arch_pkg::prn_t        commit1_prn_dest,
	output logic                  commit1_wr_en,
	output logic                  commit2_valid,
	output arch_pkg::addr_t       commit2_pc,
	output arch_pkg::arn_t        commit2_arn_dest,
	output arch_pkg::prn_t        commit2_prn_dest,
	output logic                  commit2_wr_en,
	output logic                  redirect_valid,  // fetch restarts at redirect_pc
	output arch_pkg::addr_t       redirect_pc,
	output logic [3:0]            completed_insts,
	output arch_pkg::error_code_e error_status
);

	logic [IDX_W-1:0] head_idx;
	logic             alloc1_we, alloc2_we;
	logic             accept, flush;
	logic [1:0]       retire_cnt;

	// head entries, read out of the entry array
	logic             head1_ready, head2_ready;
	arch_pkg::addr_t  head1_pc, head2_pc;
	arch_pkg::arn_t   head1_arn_dest, head2_arn_dest;
	arch_pkg::prn_t   head1_prn_dest, head2_prn_dest;
	logic             head1_is_branch, head2_is_branch;
	logic             head1_mispredict, head2_mispredict;
	arch_pkg::addr_t  head1_target, head2_target;
	logic             head1_is_halt, head2_is_halt;
	logic             head1_is_illegal, head2_is_illegal;

	//////////////////////////////////////////////////
	// pointers, entries, commit control
	//////////////////////////////////////////////////
	rob_ptrs #(
		.ROB_SIZE(ROB_SIZE)
	) rob_ptrs_i (.*);

	rob_entries #(
		.ROB_SIZE(ROB_SIZE)
	) rob_entries_i (.*);

	commit_ctrl commit_ctrl_i (.*);

endmodule

// File: commit_ctrl.sv
/* commit selection and state */

`timescale 1ns/1ps

module commit_ctrl (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  head1_ready,
	input  arch_pkg::addr_t       head1_pc,
	input  arch_pkg::arn_t        head1_arn_dest,
	input  arch_pkg::prn_t        head1_prn_dest,
	input  logic                  head1_is_branch,
	input  logic                  head1_mispredict,
	input  arch_pkg::addr_t       head1_target,
	input  logic                  head1_is_halt,
	input  logic                  head1_is_illegal,
	input  logic                  head2_ready,
	input  arch_pkg::addr_t       head2_pc,
	input  arch_pkg::arn_t        head2_arn_dest,
	input  arch_pkg::prn_t        head2_prn_dest,
	input  logic                  head2_is_branch,
	input  logic                  head2_mispredict,
	input  arch_pkg::addr_t       head2_target,
	input  logic                  head2_is_halt,
	input  logic                  head2_is_illegal,
	output logic [1:0]            retire_cnt,
	output logic                  flush,
	output logic                  accept,
	output logic                  commit1_valid,
	output arch_pkg::addr_t       commit1_pc,
	output arch_pkg::arn_t        commit1_arn_dest,
	output arch_pkg::prn_t        commit1_prn_dest,
	output logic                  commit1_wr_en,
	output logic                  commit2_valid,
	output arch_pkg::addr_t       commit2_pc,
	output arch_pkg::arn_t        commit2_arn_dest,
	output arch_pkg::prn_t        commit2_prn_dest,
	output logic                  commit2_wr_en,
	output logic [3:0]            completed_insts,
	output logic                  redirect_valid,
	output arch_pkg::addr_t       redirect_pc,
	output arch_pkg::error_code_e error_status
);

	rob_pkg::rob_state_e   state_q, state_d;
	arch_pkg::error_code_e err_q, err_d;
	logic stop1;          // head 1 ends the commit group
	logic mis1, mis2;     // committing mispredicted branch per slot
	logic stop_halt1, stop_halt2;

	//////////////////////////////////////////////////
	// commit selection
	//////////////////////////////////////////////////
	assign stop1 = (head1_is_branch && head1_mispredict) || head1_is_halt || head1_is_illegal;

	assign commit1_valid = (state_q == rob_pkg::RUN) && head1_ready;
	assign commit2_valid = commit1_valid && head2_ready && !stop1; // never past a stopper
	assign retire_cnt    = {commit2_valid, commit1_valid && !commit2_valid};
	assign completed_insts = {2'b00, retire_cnt};

	assign commit1_pc       = head1_pc;
	assign commit1_arn_dest = head1_arn_dest;
	assign commit1_prn_dest = head1_prn_dest;
	assign commit1_wr_en    = commit1_valid && (head1_arn_dest != arch_pkg::ZERO_REG);
	assign commit2_pc       = head2_pc;
	assign commit2_arn_dest = head2_arn_dest;
	assign commit2_prn_dest = head2_prn_dest;
	assign commit2_wr_en    = commit2_valid && (head2_arn_dest != arch_pkg::ZERO_REG);

	// redirect goes out with the branch itself
	assign mis1 = commit1_valid && head1_is_branch && head1_mispredict;
	assign mis2 = commit2_valid && head2_is_branch && head2_mispredict;
	assign redirect_valid = mis1 || mis2;
	assign redirect_pc    = mis1 ? head1_target : (mis2 ? head2_target : '0);

	assign stop_halt1 = commit1_valid && (head1_is_halt || head1_is_illegal);
	assign stop_halt2 = commit2_valid && (head2_is_halt || head2_is_illegal);

	assign flush        = (state_q == rob_pkg::FLUSH);
	assign accept       = (state_q == rob_pkg::RUN);
	assign error_status = err_q;

	//////////////////////////////////////////////////
	// RUN / FLUSH / HALTED
	//////////////////////////////////////////////////
	always_comb begin
		state_d = state_q;
		err_d   = err_q;
		case (state_q)
			rob_pkg::RUN: begin
				if (stop_halt1 || stop_halt2) begin
					state_d = rob_pkg::HALTED;
					// illegal before halt, slot 1 before slot 2
					if (stop_halt1)
						err_d = head1_is_illegal ? arch_pkg::HALTED_ON_ILLEGAL_I1
						                         : arch_pkg::HALTED_ON_HALT_I1;
					else
						err_d = head2_is_illegal ? arch_pkg::HALTED_ON_ILLEGAL_I2
						                         : arch_pkg::HALTED_ON_HALT_I2;
				end else if (redirect_valid) begin
					state_d = rob_pkg::FLUSH;
				end
			end
			rob_pkg::FLUSH: state_d = rob_pkg::RUN;    // single clearing cycle
			default:        state_d = rob_pkg::HALTED; // sticky until reset
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= rob_pkg::RUN;
			err_q   <= arch_pkg::NO_ERROR;
		end else begin
			state_q <= state_d;
			err_q   <= err_d;
		end
	end

endmodule

// File: rob_entries.sv
/* rob entry storage */

`timescale 1ns/1ps

module rob_entries #(
	parameter int ROB_SIZE = rob_pkg::ROB_DEPTH,
	localparam int IDX_W = $clog2(ROB_SIZE)
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               alloc1_we,
	input  logic               alloc2_we,
	input  logic [IDX_W-1:0]   inst1_rob_idx,
	input  logic [IDX_W-1:0]   inst2_rob_idx,
	input  arch_pkg::addr_t    inst1_pc,
	input  arch_pkg::arn_t     inst1_arn_dest,
	input  arch_pkg::prn_t     inst1_prn_dest,
	input  logic               inst1_is_branch,
	input  logic               inst1_is_halt,
	input  logic               inst1_is_illegal,
	input  arch_pkg::addr_t    inst2_pc,
	input  arch_pkg::arn_t     inst2_arn_dest,
	input  arch_pkg::prn_t     inst2_prn_dest,
	input  logic               inst2_is_branch,
	input  logic               inst2_is_halt,
	input  logic               inst2_is_illegal,
	input  logic               cdb1_valid,
	input  logic [IDX_W-1:0]   cdb1_rob_idx,
	input  logic               cdb1_mispredict,
	input  arch_pkg::addr_t    cdb1_value,      // branch target when a branch completes
	input  logic               cdb2_valid,
	input  logic [IDX_W-1:0]   cdb2_rob_idx,
	input  logic               cdb2_mispredict,
	input  arch_pkg::addr_t    cdb2_value,
	input  logic [IDX_W-1:0]   head_idx,
	input  logic               flush,
	output logic               head1_ready,     // occupied and executed
	output arch_pkg::addr_t    head1_pc,
	output arch_pkg::arn_t     head1_arn_dest,
	output arch_pkg::prn_t     head1_prn_dest,
	output logic               head1_is_branch,
	output logic               head1_mispredict,
	output arch_pkg::addr_t    head1_target,
	output logic               head1_is_halt,
	output logic               head1_is_illegal,
	output logic               head2_ready,
	output arch_pkg::addr_t    head2_pc,
	output arch_pkg::arn_t     head2_arn_dest,
	output arch_pkg::prn_t     head2_prn_dest,
	output logic               head2_is_branch,
	output logic               head2_mispredict,
	output arch_pkg::addr_t    head2_target,
	output logic               head2_is_halt,
	output logic               head2_is_illegal
);

	arch_pkg::addr_t   pc_q  [ROB_SIZE];
	arch_pkg::arn_t    arn_q [ROB_SIZE];
	arch_pkg::prn_t    prn_q [ROB_SIZE];
	arch_pkg::addr_t   tgt_q [ROB_SIZE];
	logic [ROB_SIZE-1:0] br_q, halt_q, ill_q, mis_q;  // per entry flags
	logic [ROB_SIZE-1:0] occ_q;      // entry holds a live inst
	logic [ROB_SIZE-1:0] exe_q;      // result bus has marked it
	logic [IDX_W-1:0]    head_prev_q; // head before the last edge
	logic [IDX_W-1:0]    ret_cnt;    // entries retired at the last edge
	logic [IDX_W-1:0]    head2_idx;

	assign ret_cnt   = head_idx - head_prev_q;
	assign head2_idx = head_idx + IDX_W'(1);

	//////////////////////////////////////////////////
	// occupied / executed bits
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			occ_q       <= '0;
			exe_q       <= '0;
			head_prev_q <= '0;
		end else if (flush) begin
			occ_q       <= '0;   // wrong path entries all dropped
			head_prev_q <= '0;   // pointers restart at zero too
		end else begin
			head_prev_q <= head_idx;
			// retired entries freed one edge late, never reachable as head 2 by then
			if (ret_cnt != '0) occ_q[head_prev_q] <= 1'b0;
			if (ret_cnt == IDX_W'(2)) occ_q[head_prev_q + IDX_W'(1)] <= 1'b0;
			if (cdb1_valid) exe_q[cdb1_rob_idx] <= 1'b1;
			if (cdb2_valid) exe_q[cdb2_rob_idx] <= 1'b1;
			if (alloc1_we) begin             // dispatch wins over a late free
				occ_q[inst1_rob_idx] <= 1'b1;
				exe_q[inst1_rob_idx] <= 1'b0;
			end
			if (alloc2_we) begin
				occ_q[inst2_rob_idx] <= 1'b1;
				exe_q[inst2_rob_idx] <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// payload, written on dispatch and completion
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (alloc1_we) begin
			pc_q[inst1_rob_idx]   <= inst1_pc;
			arn_q[inst1_rob_idx]  <= inst1_arn_dest;
			prn_q[inst1_rob_idx]  <= inst1_prn_dest;
			br_q[inst1_rob_idx]   <= inst1_is_branch;
			halt_q[inst1_rob_idx] <= inst1_is_halt;
			ill_q[inst1_rob_idx]  <= inst1_is_illegal;
		end
		if (alloc2_we) begin
			pc_q[inst2_rob_idx]   <= inst2_pc;
			arn_q[inst2_rob_idx]  <= inst2_arn_dest;
			prn_q[inst2_rob_idx]  <= inst2_prn_dest;
			br_q[inst2_rob_idx]   <= inst2_is_branch;
			halt_q[inst2_rob_idx] <= inst2_is_halt;
			ill_q[inst2_rob_idx]  <= inst2_is_illegal;
		end
		if (cdb1_valid) begin
			mis_q[cdb1_rob_idx] <= cdb1_mispredict;
			tgt_q[cdb1_rob_idx] <= cdb1_value;
		end
		if (cdb2_valid) begin
			mis_q[cdb2_rob_idx] <= cdb2_mispredict;
			tgt_q[cdb2_rob_idx] <= cdb2_value;
		end
	end

	// head reads, combinational
	assign head1_ready      = occ_q[head_idx] && exe_q[head_idx];
	assign head1_pc         = pc_q[head_idx];
	assign head1_arn_dest   = arn_q[head_idx];
	assign head1_prn_dest   = prn_q[head_idx];
	assign head1_is_branch  = br_q[head_idx];
	assign head1_mispredict = mis_q[head_idx];
	assign head1_target     = tgt_q[head_idx];
	assign head1_is_halt    = halt_q[head_idx];
	assign head1_is_illegal = ill_q[head_idx];
	assign head2_ready      = occ_q[head2_idx] && exe_q[head2_idx];
	assign head2_pc         = pc_q[head2_idx];
	assign head2_arn_dest   = arn_q[head2_idx];
	assign head2_prn_dest   = prn_q[head2_idx];
	assign head2_is_branch  = br_q[head2_idx];
	assign head2_mispredict = mis_q[head2_idx];
	assign head2_target     = tgt_q[head2_idx];
	assign head2_is_halt    = halt_q[head2_idx];
	assign head2_is_illegal = ill_q[head2_idx];

endmodule

// File: rob_ptrs.sv
/* rob head, tail and occupancy */

`timescale 1ns/1ps

module rob_ptrs #(
	parameter int ROB_SIZE = rob_pkg::ROB_DEPTH,
	localparam int IDX_W = $clog2(ROB_SIZE)
) (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             inst1_load,    // dispatch slot 1 presents an inst
	input  logic             inst2_load,    // dispatch slot 2 presents an inst
	input  logic             accept,        // commit side in RUN
	input  logic [1:0]       retire_cnt,    // entries leaving this cycle
	input  logic             flush,         // clear everything at the next edge
	output logic             alloc1_we,
	output logic             alloc2_we,
	output logic [IDX_W-1:0] inst1_rob_idx,
	output logic [IDX_W-1:0] inst2_rob_idx,
	output logic [IDX_W-1:0] head_idx,
	output logic             rob_full
);

	logic [IDX_W-1:0] head_q;     // oldest entry
	logic [IDX_W-1:0] tail_q;     // next free entry
	logic [IDX_W:0]   count_q;    // occupancy, 0..ROB_SIZE
	logic [IDX_W:0]   n_alloc;    // entries written this cycle

	// room for two more is required before accepting anything
	assign rob_full = (count_q > (IDX_W+1)'(ROB_SIZE - 2)) || !accept;

	assign alloc1_we = inst1_load && !rob_full;
	assign alloc2_we = inst2_load && !rob_full;
	assign n_alloc   = (IDX_W+1)'(alloc1_we) + (IDX_W+1)'(alloc2_we);

	assign inst1_rob_idx = tail_q;
	assign inst2_rob_idx = inst1_load ? tail_q + IDX_W'(1) : tail_q; // slot 2 alone takes tail
	assign head_idx      = head_q;

	//////////////////////////////////////////////////
	// counters, all wrap at ROB_SIZE
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else if (flush) begin
			head_q  <= '0;   // mispredict recovery restarts at entry 0
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			head_q  <= head_q + IDX_W'(retire_cnt);
			tail_q  <= tail_q + IDX_W'(n_alloc);
			count_q <= count_q + n_alloc - (IDX_W+1)'(retire_cnt);
		end
	end

endmodule

// File: rob_pkg.sv
/* reorder buffer definitions */

package rob_pkg;

	localparam int ROB_DEPTH = 16;   // default entry count, power of two

	// commit side state
	typedef enum logic [1:0] {
		RUN    = 2'd0,  // normal dispatch and commit
		FLUSH  = 2'd1,  // one cycle of clearing after a mispredict
		HALTED = 2'd2   // left only by reset
	} rob_state_e;

endpackage

// File: arch_pkg.sv
/* architectural definitions */

package arch_pkg;

	typedef logic [4:0]  arn_t;      // architectural register number, 32 regs
	typedef logic [5:0]  prn_t;      // physical register number, 64 regs
	typedef logic [63:0] addr_t;     // instruction address / branch target

	// writes to this register are discarded at commit
	localparam arn_t ZERO_REG = 5'd31;

	// halt status, latched when a halt or illegal inst leaves the core
	typedef enum logic [2:0] {
		NO_ERROR             = 3'd0,
		HALTED_ON_HALT_I1    = 3'd1, // halt in commit slot 1
		HALTED_ON_ILLEGAL_I1 = 3'd2, // illegal in commit slot 1
		HALTED_ON_HALT_I2    = 3'd3, // halt in commit slot 2
		HALTED_ON_ILLEGAL_I2 = 3'd4  // illegal in commit slot 2
	} error_code_e;

endpackage
